//--- design/trellis_config.svh
`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// width of one signed sample component, real or imaginary
`define TRELLIS_SAMPLE_WIDTH 18

// path metric width, branch metric is one bit wider
`define TRELLIS_METRIC_WIDTH 18

// 4-state code, generators 7 and 5
`define TRELLIS_STATES 4

// qpsk component amplitude of an expected symbol
`define TRELLIS_SYMBOL_AMP 8192

// reset metric of states 1 to 3, state 0 starts at zero
`define TRELLIS_INIT_METRIC 4096

// pipeline depth of cmagSquared
`define TRELLIS_MAG_LATENCY 2

`endif

//--- design/trellisPkg.sv
`default_nettype none

`include "trellis_config.svh"

package trellisPkg;

    // one real or imaginary sample component
    typedef logic signed [`TRELLIS_SAMPLE_WIDTH-1:0] sampleT;

    // accumulated path metric
    typedef logic [`TRELLIS_METRIC_WIDTH-1:0] metricT;

    // squared distance, one bit wider than a path metric
    typedef logic [`TRELLIS_METRIC_WIDTH:0] branchMetricT;

    // trellis state index
    typedef logic [$clog2(`TRELLIS_STATES)-1:0] stateIdxT;

    // one survivor bit per state
    typedef logic [`TRELLIS_STATES-1:0] decisionT;

    // sequencing of one sample through the core
    typedef enum logic [1:0] {ctrlIdle, ctrlBusy, ctrlHold} ctrlStateT;

endpackage

`default_nettype wire

//--- design/cmagSquared.sv
`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module cmagSquared (
    input  wire  logic              clk,
    input  wire  logic              rstN,
    input  wire  trellisPkg::sampleT inReal,
    input  wire  trellisPkg::sampleT inImag,
    output trellisPkg::branchMetricT magSquared
);
    import trellisPkg::*;

    // scale of each square back into metric range
    localparam int prodShift = 17;

    // full-width squares, operands widen to the target before the multiply
    logic signed [2*`TRELLIS_SAMPLE_WIDTH-1:0] prodReal;
    logic signed [2*`TRELLIS_SAMPLE_WIDTH-1:0] prodImag;
    branchMetricT sqReal;
    branchMetricT sqImag;

    assign prodReal = inReal * inReal;
    assign prodImag = inImag * inImag;

    // stage one: scaled squares
    // stage two: their sum
    always_ff @(posedge clk) begin
        if (!rstN) begin
            sqReal     <= '0;
            sqImag     <= '0;
            magSquared <= '0;
        end else begin
            // squares are never negative, so the shift drops only fraction bits
            sqReal     <= branchMetricT'(prodReal >>> prodShift);
            sqImag     <= branchMetricT'(prodImag >>> prodShift);
            magSquared <= sqReal + sqImag;
        end
    end

endmodule

`default_nettype wire

//--- design/acsOp.sv
`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module acsOp (
    input  wire  logic               clk,
    input  wire  logic               rstN,
    input  wire  trellisPkg::sampleT yReal,
    input  wire  trellisPkg::sampleT yImag,
    input  wire  trellisPkg::sampleT sReal,
    input  wire  trellisPkg::sampleT sImag,
    input  wire  logic               accMetricInEn,
    input  wire  trellisPkg::metricT accMetricIn,
    output logic                     accMetricOutEn,
    output trellisPkg::metricT       accMetricOut
);
    import trellisPkg::*;

    sampleT       diffReal;
    sampleT       diffImag;
    branchMetricT branchMetric;
    metricT       accDelay [`TRELLIS_MAG_LATENCY];
    branchMetricT accSum;
    logic [`TRELLIS_MAG_LATENCY:0] enDelay;

    // half-scaled difference y/2 - s/2, range stays inside sampleT
    assign diffReal = (yReal >>> 1) - (sReal >>> 1);
    assign diffImag = (yImag >>> 1) - (sImag >>> 1);

    // branch metric |y - s|^2
    cmagSquared cmagSquared_i (
        .clk        (clk),
        .rstN       (rstN),
        .inReal     (diffReal),
        .inImag     (diffImag),
        .magSquared (branchMetric)
    );

    // line the path metric up with the magnitude pipeline
    always_ff @(posedge clk) begin
        accDelay[0] <= accMetricIn;
        for (int i = 1; i < `TRELLIS_MAG_LATENCY; i++) begin
            accDelay[i] <= accDelay[i-1];
        end
    end

    // registered sum, top bit flags overflow of the metric width
    always_ff @(posedge clk) begin
        accSum <= branchMetricT'(accDelay[`TRELLIS_MAG_LATENCY-1]) + branchMetric;
    end

    // saturate after the register to keep the adder path short
    assign accMetricOut = accSum[`TRELLIS_METRIC_WIDTH] ? '1
                        : accSum[`TRELLIS_METRIC_WIDTH-1:0];

    // enable follows magnitude latency plus the sum register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            enDelay <= '0;
        end else begin
            enDelay <= {enDelay[`TRELLIS_MAG_LATENCY-1:0], accMetricInEn};
        end
    end

    assign accMetricOutEn = enDelay[`TRELLIS_MAG_LATENCY];

    // single-cycle enable, and never while an earlier one is still in the delay line
    singleInFlight: assert property (@(posedge clk) disable iff (!rstN)
        accMetricInEn |-> enDelay == '0);

endmodule

`default_nettype wire

//--- design/compareSelect.sv
`timescale 1ns/1ps
`default_nettype none

module compareSelect (
    input  wire  logic               clk,
    input  wire  logic               rstN,
    input  wire  trellisPkg::metricT candZero,
    input  wire  trellisPkg::metricT candOne,
    input  wire  logic               enable,
    output trellisPkg::metricT       selMetric,
    output logic                     decision
);
    import trellisPkg::*;

    logic pickOne;

    // strict compare, a tie keeps the s0 = 0 predecessor
    assign pickOne = (candOne < candZero);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            selMetric <= '0;
            decision  <= 1'b0;
        end else if (enable) begin
            if (pickOne) begin
                selMetric <= candOne;
                decision  <= 1'b1;
            end else begin
                selMetric <= candZero;
                decision  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/pathMetricStore.sv
`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module pathMetricStore (
    input  wire  logic                 clk,
    input  wire  logic                 rstN,
    input  wire  trellisPkg::metricT   newMetrics [`TRELLIS_STATES],
    input  wire  trellisPkg::decisionT newDecisions,
    input  wire  logic                 write,
    input  wire  logic                 outReady,
    output trellisPkg::metricT         stateMetrics [`TRELLIS_STATES],
    output trellisPkg::decisionT       decisions,
    output trellisPkg::stateIdxT       bestState,
    output trellisPkg::metricT         minMetric,
    output logic                       outValid
);
    import trellisPkg::*;

    metricT   minVal;
    stateIdxT minIdx;

    // minimum over the new metrics
    // strict compare so the lowest index wins a tie
    always_comb begin
        minVal = newMetrics[0];
        minIdx = '0;
        for (int i = 1; i < `TRELLIS_STATES; i++) begin
            if (newMetrics[i] < minVal) begin
                minVal = newMetrics[i];
                minIdx = stateIdxT'(i);
            end
        end
    end

    // state metrics, normalized so the best path sits at zero
    always_ff @(posedge clk) begin
        if (!rstN) begin
            // start in state 0, others carry a penalty
            stateMetrics[0] <= '0;
            for (int i = 1; i < `TRELLIS_STATES; i++) begin
                stateMetrics[i] <= metricT'(`TRELLIS_INIT_METRIC);
            end
        end else if (write) begin
            for (int i = 0; i < `TRELLIS_STATES; i++) begin
                stateMetrics[i] <= newMetrics[i] - minVal;
            end
        end
    end

    // result fields, only change on a write so they hold under a stall
    always_ff @(posedge clk) begin
        if (write) begin
            decisions <= newDecisions;
            bestState <= minIdx;
            minMetric <= minVal;
        end
    end

    // valid held until the consumer takes the result
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (write) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/acsController.sv
`timescale 1ns/1ps
`default_nettype none

module acsController (
    input  wire  logic               clk,
    input  wire  logic               rstN,
    input  wire  trellisPkg::sampleT inReal,
    input  wire  trellisPkg::sampleT inImag,
    input  wire  logic               inValid,
    output logic                     inReady,
    output logic                     acsStart,
    output trellisPkg::sampleT       sampleReal,
    output trellisPkg::sampleT       sampleImag,
    input  wire  logic               acsDone,
    output logic                     selDone,
    input  wire  logic               outValid,
    input  wire  logic               outReady
);
    import trellisPkg::*;

    ctrlStateT state;

    // metrics feed back into the next sample, so only one is in flight
    assign inReady = (state == ctrlIdle);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= ctrlIdle;
            acsStart <= 1'b0;
            selDone  <= 1'b0;
        end else begin
            // both strobes are single-cycle pulses
            acsStart <= 1'b0;
            selDone  <= 1'b0;
            case (state)
                ctrlIdle: begin
                    if (inValid) begin
                        acsStart <= 1'b1;
                        state    <= ctrlBusy;
                    end
                end
                ctrlBusy: begin
                    // compare-select registers on acsDone, store writes a cycle later
                    if (acsDone) begin
                        selDone <= 1'b1;
                        state   <= ctrlHold;
                    end
                end
                ctrlHold: begin
                    if (outValid && outReady) begin
                        state <= ctrlIdle;
                    end
                end
                default: state <= ctrlIdle;
            endcase
        end
    end

    // sample held for the whole magnitude pipeline
    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            sampleReal <= inReal;
            sampleImag <= inImag;
        end
    end

    // never accept while a result is pending at the output
    readyValidExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(inReady && outValid));

    // branch results only arrive while the FSM waits for them
    doneWhileBusy: assert property (@(posedge clk) disable iff (!rstN)
        acsDone |-> state == ctrlBusy);

endmodule

`default_nettype wire

//--- design/trellisAcsUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module trellisAcsUnit (
    input  wire  logic               clk,
    input  wire  logic               rstN,
    input  wire  trellisPkg::sampleT inReal,
    input  wire  trellisPkg::sampleT inImag,
    input  wire  logic               inValid,
    output logic                     inReady,
    input  wire  logic               outReady,
    output logic                     outValid,
    output trellisPkg::decisionT     decisions,
    output trellisPkg::stateIdxT     bestState,
    output trellisPkg::metricT       minMetric
);
    import trellisPkg::*;

    logic     acsStart;
    logic     acsDone;
    logic     selDone;
    sampleT   sampleReal;
    sampleT   sampleImag;
    metricT   stateMetrics [`TRELLIS_STATES];
    metricT   branchSums [2*`TRELLIS_STATES];
    logic     branchEn [2*`TRELLIS_STATES];
    metricT   newMetrics [`TRELLIS_STATES];
    decisionT newDecisions;

    acsController acsController_i (
        .clk        (clk),
        .rstN       (rstN),
        .inReal     (inReal),
        .inImag     (inImag),
        .inValid    (inValid),
        .inReady    (inReady),
        .acsStart   (acsStart),
        .sampleReal (sampleReal),
        .sampleImag (sampleImag),
        .acsDone    (acsDone),
        .selDone    (selDone),
        .outValid   (outValid),
        .outReady   (outReady)
    );

    // all branches run in lockstep, branch 0 stands for the set
    assign acsDone = branchEn[0];

    // branch k = 2n + s0 enters next state n from predecessor {n[0], s0}
    for (genvar k = 0; k < 2*`TRELLIS_STATES; k++) begin : gBranch
        localparam int nextState = k / 2;
        localparam int predS0    = k % 2;
        localparam int predS1    = nextState % 2;
        // input bit is the top bit of the next state
        localparam int bitIn     = nextState / 2;
        localparam int predState = 2*predS1 + predS0;
        // generators 7 and 5
        localparam int g0 = bitIn ^ predS1 ^ predS0;
        localparam int g1 = bitIn ^ predS0;
        localparam sampleT symReal = (g0 != 0) ? sampleT'(-`TRELLIS_SYMBOL_AMP)
                                               : sampleT'(`TRELLIS_SYMBOL_AMP);
        localparam sampleT symImag = (g1 != 0) ? sampleT'(-`TRELLIS_SYMBOL_AMP)
                                               : sampleT'(`TRELLIS_SYMBOL_AMP);

        acsOp acsOp_i (
            .clk            (clk),
            .rstN           (rstN),
            .yReal          (sampleReal),
            .yImag          (sampleImag),
            .sReal          (symReal),
            .sImag          (symImag),
            .accMetricInEn  (acsStart),
            .accMetricIn    (stateMetrics[predState]),
            .accMetricOutEn (branchEn[k]),
            .accMetricOut   (branchSums[k])
        );
    end

    // one compare-select per next state, fed by its two predecessor branches
    for (genvar n = 0; n < `TRELLIS_STATES; n++) begin : gState
        compareSelect compareSelect_i (
            .clk       (clk),
            .rstN      (rstN),
            .candZero  (branchSums[2*n]),
            .candOne   (branchSums[2*n+1]),
            .enable    (branchEn[2*n] & branchEn[2*n+1]),
            .selMetric (newMetrics[n]),
            .decision  (newDecisions[n])
        );
    end

    pathMetricStore pathMetricStore_i (
        .clk          (clk),
        .rstN         (rstN),
        .newMetrics   (newMetrics),
        .newDecisions (newDecisions),
        .write        (selDone),
        .outReady     (outReady),
        .stateMetrics (stateMetrics),
        .decisions    (decisions),
        .bestState    (bestState),
        .minMetric    (minMetric),
        .outValid     (outValid)
    );

endmodule

`default_nettype wire

//--- tests/trellisAcsUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "trellis_config.svh"

module trellisAcsUnitTb;
    import trellisPkg::*;

    // one stimulus row with an optional hand-worked expectation
    typedef struct packed {
        int       re;
        int       im;
        int       stall;
        bit       rst;
        bit       fixed;
        bit       fixDec;
        decisionT expDec;
        int       expBest;
        int       expMin;
    } rowT;

    localparam int amp = `TRELLIS_SYMBOL_AMP;
    localparam longint metricMax = (longint'(1) << `TRELLIS_METRIC_WIDTH) - 1;

    logic     clk;
    logic     rstN;
    sampleT   inReal;
    sampleT   inImag;
    logic     inValid;
    logic     inReady;
    logic     outReady;
    logic     outValid;
    decisionT decisions;
    stateIdxT bestState;
    metricT   minMetric;

    rowT         rows [$];
    longint      pm [`TRELLIS_STATES];
    logic [15:0] lfsrState;
    int          errors = 0;
    int          watchCycles = 0;
    logic        tableBuilt = 1'b0;

    trellisAcsUnit trellisAcsUnit_i (
        .clk       (clk),
        .rstN      (rstN),
        .inReal    (inReal),
        .inImag    (inImag),
        .inValid   (inValid),
        .inReady   (inReady),
        .outReady  (outReady),
        .outValid  (outValid),
        .decisions (decisions),
        .bestState (bestState),
        .minMetric (minMetric)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic reportMismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    // galois lfsr, one step per bit handed out
    function automatic logic [31:0] lfsrBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
        end
        return bits;
    endfunction

    // squared half-scaled distance of one component
    function automatic longint branchDistance(input longint y, input longint s);
        longint d;
        d = (y >>> 1) - (s >>> 1);
        return (d * d) >>> 17;
    endfunction

    function automatic void modelReset();
        pm[0] = 0;
        for (int n = 1; n < `TRELLIS_STATES; n++) begin
            pm[n] = `TRELLIS_INIT_METRIC;
        end
    endfunction

    // one trellis step: branch metrics, saturating sums, compare-select, normalization
    task automatic modelStep(input longint yr, input longint yi, output decisionT dec,
                             output int best, output longint minV);
        longint cand [2];
        longint newM [`TRELLIS_STATES];
        int     b;
        int     s1;
        int     pred;
        longint sr;
        longint si;
        for (int n = 0; n < `TRELLIS_STATES; n++) begin
            // next state n = {b, s1}, predecessor {s1, s0}
            b  = n / 2;
            s1 = n % 2;
            for (int s0 = 0; s0 < 2; s0++) begin
                pred = 2 * s1 + s0;
                sr = ((b ^ s1 ^ s0) != 0) ? -amp : amp;
                si = ((b ^ s0) != 0) ? -amp : amp;
                cand[s0] = pm[pred] + branchDistance(yr, sr) + branchDistance(yi, si);
                if (cand[s0] > metricMax) begin
                    cand[s0] = metricMax;
                end
            end
            // tie keeps s0 = 0
            dec[n]  = (cand[1] < cand[0]);
            newM[n] = dec[n] ? cand[1] : cand[0];
        end
        best = 0;
        minV = newM[0];
        for (int n = 1; n < `TRELLIS_STATES; n++) begin
            if (newM[n] < minV) begin
                best = n;
                minV = newM[n];
            end
        end
        for (int n = 0; n < `TRELLIS_STATES; n++) begin
            pm[n] = newM[n] - minV;
        end
    endtask

    function automatic void addRow(input int re, input int im, input int stall, input bit rst,
                                   input bit fixed, input bit fixDec, input decisionT expDec,
                                   input int expBest, input int expMin);
        rowT r;
        r.re      = re;
        r.im      = im;
        r.stall   = stall;
        r.rst     = rst;
        r.fixed   = fixed;
        r.fixDec  = fixDec;
        r.expDec  = expDec;
        r.expBest = expBest;
        r.expMin  = expMin;
        rows.push_back(r);
    endfunction

    function automatic void buildTable();
        sampleT re;
        sampleT im;
        int     resets;
        // noiseless path for bits 1 0 1 1 0 0 1 0 from state 0, best follows the encoder
        addRow(-amp, -amp, 0, 0, 1, 0, '0, 2, 0);
        addRow(-amp,  amp, 2, 0, 1, 0, '0, 1, 0);
        addRow( amp,  amp, 0, 0, 1, 0, '0, 2, 0);
        addRow( amp, -amp, 5, 0, 1, 0, '0, 3, 0);
        addRow( amp, -amp, 0, 0, 1, 0, '0, 1, 0);
        addRow(-amp, -amp, 1, 0, 1, 0, '0, 0, 0);
        addRow(-amp, -amp, 0, 0, 1, 0, '0, 2, 0);
        addRow(-amp,  amp, 3, 0, 1, 0, '0, 1, 0);
        // zero samples after a reset, every branch costs 256 and equal metrics tie
        addRow(0, 0, 0, 1, 1, 1, 4'b0000, 0, 256);
        addRow(0, 0, 4, 0, 1, 1, 4'b0000, 0, 256);
        addRow(0, 0, 0, 0, 1, 1, 4'b0000, 0, 256);
        // full-scale opposite-sign samples for the widest branch metrics
        addRow( 131071, -131072, 0, 0, 0, 0, '0, 0, 0);
        addRow(-131072,  131071, 2, 0, 0, 0, '0, 0, 0);
        addRow( 131071, -131072, 0, 0, 0, 0, '0, 0, 0);
        addRow( 131071, -131072, 3, 0, 0, 0, '0, 0, 0);
        addRow(-131072,  131071, 0, 0, 0, 0, '0, 0, 0);
        addRow(-131072,  131071, 1, 0, 0, 0, '0, 0, 0);
        for (int i = 0; i < 40; i++) begin
            re = sampleT'(lfsrBits(18));
            im = sampleT'(lfsrBits(18));
            addRow(int'(re), int'(im), int'(lfsrBits(2)), 0, 0, 0, '0, 0, 0);
        end
        resets = 1;
        foreach (rows[i]) begin
            if (rows[i].rst) begin
                resets++;
            end
        end
        // 30 cycles per row plus every reset
        watchCycles = rows.size() * 30 + resets * 17 + 16;
    endfunction

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        modelReset();
    endtask

    task automatic runRow(input rowT r, input int idx);
        decisionT expDec;
        int       expBest;
        longint   expMin;
        decisionT heldDec;
        stateIdxT heldBest;
        metricT   heldMin;
        int       lat;
        modelStep(longint'(r.re), longint'(r.im), expDec, expBest, expMin);
        @(posedge clk);
        inReal  <= sampleT'(r.re);
        inImag  <= sampleT'(r.im);
        inValid <= 1'b1;
        @(negedge clk);
        while (!inReady) @(negedge clk);
        // accept edge
        @(posedge clk);
        inValid <= 1'b0;
        // whole cycles from the accept edge until outValid shows up
        lat = 0;
        @(negedge clk);
        while (!outValid && lat < 20) begin
            assert (!inReady)
                else reportMismatch($sformatf("row %0d inReady high while busy", idx));
            @(negedge clk);
            lat++;
        end
        assert (lat == 5)
            else reportMismatch($sformatf("row %0d outValid after %0d cycles, not 5", idx, lat));
        assert (decisions == expDec)
            else reportMismatch($sformatf("row %0d decisions %b, model %b", idx, decisions, expDec));
        assert (int'(bestState) == expBest)
            else reportMismatch($sformatf("row %0d bestState %0d, model %0d", idx, bestState,
                                          expBest));
        assert (longint'(minMetric) == expMin)
            else reportMismatch($sformatf("row %0d minMetric %0d, model %0d", idx, minMetric,
                                          expMin));
        if (r.fixed) begin
            assert (int'(bestState) == r.expBest && int'(minMetric) == r.expMin)
                else reportMismatch($sformatf("row %0d best %0d min %0d, fixed %0d %0d", idx,
                                              bestState, minMetric, r.expBest, r.expMin));
            if (r.fixDec) begin
                assert (decisions == r.expDec)
                    else reportMismatch($sformatf("row %0d decisions %b, fixed %b", idx,
                                                  decisions, r.expDec));
            end
        end
        heldDec  = decisions;
        heldBest = bestState;
        heldMin  = minMetric;
        // back-pressure, the result must sit still
        for (int i = 0; i < r.stall; i++) begin
            @(negedge clk);
            assert (outValid && !inReady && decisions == heldDec && bestState == heldBest
                    && minMetric == heldMin)
                else reportMismatch($sformatf("row %0d result moved during stall", idx));
        end
        @(posedge clk);
        outReady <= 1'b1;
        // handshake edge
        @(posedge clk);
        outReady <= 1'b0;
        @(negedge clk);
        assert (!outValid && inReady)
            else reportMismatch($sformatf("row %0d result not taken exactly once", idx));
    endtask

    initial begin
        wait (tableBuilt);
        repeat (watchCycles) @(posedge clk);
        $display("watchdog expired after %0d cycles, the DUT stopped responding", watchCycles);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        rstN      = 1'b0;
        inReal    = '0;
        inImag    = '0;
        inValid   = 1'b0;
        outReady  = 1'b0;
        lfsrState = 16'd61;
        buildTable();
        tableBuilt = 1'b1;
        applyReset();
        foreach (rows[i]) begin
            if (rows[i].rst) begin
                applyReset();
            end
            runRow(rows[i], i);
        end
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/trellisPkg.sv
design/cmagSquared.sv
design/acsOp.sv
design/compareSelect.sv
design/pathMetricStore.sv
design/acsController.sv
design/trellisAcsUnit.sv
tests/trellisAcsUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the trellis ACS testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module trellisAcsUnitTb -o simv
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simv 2>&1)
simStatus=$?
echo "$simOut"

if [ $simStatus -ne 0 ]; then
    echo "simulator exited with status $simStatus"
    exit 1
fi

# pass only when the testbench printed its pass line
if grep -qx "Simulation passed" <<< "$simOut"; then
    exit 0
else
    echo "pass line not found in simulator output"
    exit 1
fi
